//--- build.f
+incdir+.
viz_pkg.sv
video_timing.sv
drum_envelope.sv
circle_hollow.sv
square_hollow_noise.sv
star_noise.sv
dry_gen.sv
drum_viz_top.sv
tb_drum_viz.sv

//--- tb_drum_viz.sv
`timescale 1ns/1ns
`include "viz_consts.svh"

module tb_drum_viz;

  localparam int FRAME = `VIZ_H_TOTAL * `VIZ_V_TOTAL;

  typedef struct packed {
    viz_pkg::voice_trig_t trig;
    logic [3:0]           frames;
    logic [10:0]          h;
    logic [9:0]           v;
  } row_t;

  logic                 clk;
  logic                 rst;
  viz_pkg::voice_trig_t trig;
  viz_pkg::level_t      pixel;
  viz_pkg::raster_pos_t pos_out;

  row_t  rows[$];
  string names[$];
  int    model_env [`VIZ_VOICES];
  int    cycles = 0;
  int    limit = 0;

  drum_viz_top DUT (
    .clk    (clk),
    .rst    (rst),
    .trig   (trig),
    .pixel  (pixel),
    .pos_out(pos_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("simulation hung: probe never reached after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input int expected, input int actual,
                             input bit at_least);
    if (at_least ? (actual < expected) : (actual != expected)) begin
      if (at_least) begin
        $display("[FAIL] %s expected at least %0d actual %0d", name, expected, actual);
      end else begin
        $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
      end
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input string name, input logic [2:0] strike, input int velocity,
                         input int frames, input int h, input int v);
    row_t row;
    row.trig.strike   = strike;
    row.trig.velocity = velocity[7:0];
    row.frames        = frames[3:0];
    row.h             = h[10:0];
    row.v             = v[9:0];
    rows.push_back(row);
    names.push_back(name);
    limit += (frames + 2) * FRAME;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_pos(input int h, input int v);
    do begin
      step();
    end while (!(pos_out.active_draw && pos_out.h_count == h && pos_out.v_count == v));
  endtask

  task automatic decay_model();
    for (int i = 0; i < `VIZ_VOICES; i++) begin
      model_env[i] = (model_env[i] > `VIZ_DECAY_STEP) ? model_env[i] - `VIZ_DECAY_STEP : 0;
    end
  endtask

  // one frame start lies between two origins on the output
  task automatic wait_origin();
    wait_pos(0, 0);
    decay_model();
  endtask

  task automatic strike_voices(input logic [2:0] strike, input logic [7:0] velocity);
    trig.strike   = strike;
    trig.velocity = velocity;
    for (int i = 0; i < `VIZ_VOICES; i++) begin
      if (strike[i]) begin
        model_env[i] = velocity;
      end
    end
  endtask

  function automatic int absdiff(input int a, input int b);
    return (a > b) ? a - b : b - a;
  endfunction

  // expected pixel or a floor where noise can only add
  function automatic int model_pixel(input int h, input int v, output bit exact);
    int dx;
    int dy;
    int val;
    int voice;
    int half;
    voice = 0;
    val   = 0;
    exact = 1'b1;
    half  = `VIZ_SD_WIDTH / 2;
    dx = absdiff(h, `VIZ_BD_CX);
    dy = absdiff(v, `VIZ_BD_CY);
    if (dx < `VIZ_BD_RADIUS && dy < `VIZ_BD_RADIUS &&
        dx * dx + dy * dy < `VIZ_BD_RADIUS * `VIZ_BD_RADIUS) begin
      val = (dx * dx + dy * dy) * 256 / (`VIZ_BD_RADIUS * `VIZ_BD_RADIUS);
    end
    dx = absdiff(h, `VIZ_SD_CX);
    dy = absdiff(v, `VIZ_SD_CY);
    if (dx < half && dy < half) begin
      voice = 1;
      exact = 1'b0;
      val   = 255 - (half - 1 - ((dx > dy) ? dx : dy)) * (256 / half);
    end
    dx = absdiff(h, `VIZ_HH_CX);
    dy = absdiff(v, `VIZ_HH_CY);
    if (dx < (1 << `VIZ_HH_WIDTH_POW) && dy < (1 << `VIZ_HH_HEIGHT_POW)) begin
      voice = 2;
      exact = 1'b0;
      val   = 256 - dx * (512 >> `VIZ_HH_WIDTH_POW) - dy * (512 >> `VIZ_HH_HEIGHT_POW)
              - ((dx * dx * dy * dy) >> (4 * `VIZ_HH_HEIGHT_POW - 16));
      val   = (val < 0) ? 0 : ((val > 255) ? 255 : val);
    end
    if (model_env[voice] == 0) begin
      exact = 1'b1;
    end
    return (model_env[voice] * val) >> 8;
  endfunction

  // walk one frame checking the raster position and blanking
  task automatic scan_frame(input string name, input logic [2:0] strike);
    int h;
    int v;
    bit visible;
    wait_origin();
    strike_voices(strike, 8'd255);
    for (int i = 0; i < FRAME; i++) begin
      if (i > 0) begin
        step();
      end
      if (i == 1) begin
        trig = '0;
      end
      h       = i % `VIZ_H_TOTAL;
      v       = i / `VIZ_H_TOTAL;
      visible = (h < `VIZ_H_ACTIVE) && (v < `VIZ_V_ACTIVE);
      check_value({name, "_h"}, h, pos_out.h_count, 1'b0);
      check_value({name, "_v"}, v, pos_out.v_count, 1'b0);
      check_value({name, "_active"}, visible, pos_out.active_draw, 1'b0);
      if (strike == 3'b000 || !visible) begin
        check_value(name, 0, pixel, 1'b0);
      end
    end
  endtask

  initial begin
    row_t row;
    int   expected;
    bit   exact;
    trig = '0;
    rst  = 1'b1;
    for (int i = 0; i < `VIZ_VOICES; i++) begin
      model_env[i] = 0;
    end
    add_row("settle", 3'b000, 0, 8, 143, 100);
    add_row("bd_rim", 3'b001, 255, 0, 143, 100);
    add_row("bd_diag", 3'b001, 255, 0, 125, 145);
    add_row("bd_inner", 3'b001, 255, 0, 90, 120);
    add_row("bd_center", 3'b001, 255, 0, 80, 100);
    add_row("bd_out_x", 3'b001, 255, 0, 144, 100);
    add_row("bd_out_diag", 3'b001, 255, 0, 126, 146);
    add_row("bd_half_vel", 3'b001, 128, 0, 143, 100);
    add_row("bd_decay", 3'b001, 255, 8, 143, 100);
    add_row("sd_edge", 3'b010, 255, 0, 231, 60);
    add_row("sd_center", 3'b010, 255, 0, 200, 60);
    add_row("sd_mid", 3'b010, 255, 0, 210, 50);
    add_row("sd_gap", 3'b010, 255, 0, 160, 60);
    add_row("sd_far", 3'b010, 255, 0, 300, 20);
    add_row("sd_fade", 3'b000, 0, 8, 231, 60);
    add_row("hh_center", 3'b100, 255, 0, 260, 150);
    add_row("hh_inner", 3'b100, 255, 0, 270, 152);
    add_row("hh_off_x", 3'b100, 255, 0, 195, 150);
    add_row("hh_off_y", 3'b100, 255, 0, 260, 182);
    add_row("hh_bd_quiet", 3'b100, 255, 0, 143, 100);
    add_row("hh_sd_quiet", 3'b100, 255, 0, 231, 60);
    // two scan frames may each wait a frame for the origin
    limit += 6 * FRAME;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    scan_frame("idle_frame", 3'b000);
    scan_frame("blanking", 3'b111);
    for (int r = 0; r < rows.size(); r++) begin
      row = rows[r];
      wait_origin();
      strike_voices(row.trig.strike, row.trig.velocity);
      step();
      trig = '0;
      for (int k = 0; k <= row.frames; k++) begin
        if (k > 0) begin
          decay_model();
        end
        wait_pos(row.h, row.v);
        expected = model_pixel(row.h, row.v, exact);
        check_value(names[r], expected, pixel, !exact);
      end
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- drum_viz_top.sv
`timescale 1ns/1ns
`include "viz_consts.svh"

module drum_viz_top (
  input  logic                 clk,
  input  logic                 rst,
  input  viz_pkg::voice_trig_t trig,
  output viz_pkg::level_t      pixel,
  output viz_pkg::raster_pos_t pos_out
);

  viz_pkg::raster_pos_t pos;
  viz_pkg::raster_pos_t pos_q [`VIZ_PIPE_DEPTH];
  logic                 frame_start;
  viz_pkg::level_t      env [`VIZ_VOICES-1:0];
  viz_pkg::level_t      intensity;

  video_timing u_timing (
    .clk        (clk),
    .rst        (rst),
    .pos        (pos),
    .frame_start(frame_start)
  );

  drum_envelope u_env (
    .clk        (clk),
    .rst        (rst),
    .trig       (trig),
    .frame_start(frame_start),
    .env        (env)
  );

  dry_gen u_dry (
    .clk      (clk),
    .rst      (rst),
    .pos      (pos),
    .env      (env),
    .intensity(intensity)
  );

  // position follows the pixel through the pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `VIZ_PIPE_DEPTH; i++) begin
        pos_q[i] <= '0;
      end
    end else begin
      pos_q[0] <= pos;
      for (int i = 1; i < `VIZ_PIPE_DEPTH; i++) begin
        pos_q[i] <= pos_q[i-1];
      end
    end
  end

  assign pos_out = pos_q[`VIZ_PIPE_DEPTH-1];
  assign pixel   = pos_out.active_draw ? intensity : 8'd0;

  // nothing drawn outside the visible area
  a_blank: assert property (@(posedge clk) disable iff (rst)
    (pos_out.h_count >= `VIZ_H_ACTIVE || pos_out.v_count >= `VIZ_V_ACTIVE)
    |-> pixel == 8'd0);

endmodule

//--- dry_gen.sv
`timescale 1ns/1ns
`include "viz_consts.svh"

module dry_gen (
  input  logic                 clk,
  input  logic                 rst,
  input  viz_pkg::raster_pos_t pos,
  input  viz_pkg::level_t      env [`VIZ_VOICES-1:0],
  output viz_pkg::level_t      intensity
);

  logic [31:0]     lfsr;
  viz_pkg::level_t noise;
  viz_pkg::level_t shape [`VIZ_VOICES-1:0];
  viz_pkg::level_t mix_in [`VIZ_VOICES-1:0];
  viz_pkg::level_t bd_d1;
  viz_pkg::level_t bd_d2;
  viz_pkg::level_t sd_d1;
  viz_pkg::level_t sd_d2;
  logic [17:0]     sum_full;
  logic [15:0]     sum_sat;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= `VIZ_LFSR_SEED;
    end else begin
      lfsr <= (lfsr << 1) ^ ({32{lfsr[31]}} & `VIZ_LFSR_TAPS);
    end
  end

  assign noise = {lfsr[0], lfsr[5], lfsr[3], lfsr[7], lfsr[1], lfsr[4], lfsr[6], lfsr[2]};

  circle_hollow #(
    .RADIUS  (`VIZ_BD_RADIUS),
    .CENTER_X(`VIZ_BD_CX),
    .CENTER_Y(`VIZ_BD_CY)
  ) u_bd (
    .clk      (clk),
    .rst      (rst),
    .pos      (pos),
    .intensity(shape[0])
  );

  square_hollow_noise #(
    .WIDTH   (`VIZ_SD_WIDTH),
    .CENTER_X(`VIZ_SD_CX),
    .CENTER_Y(`VIZ_SD_CY)
  ) u_sd (
    .clk      (clk),
    .rst      (rst),
    .pos      (pos),
    .noise    (noise),
    .intensity(shape[1])
  );

  star_noise #(
    .WIDTH_POW (`VIZ_HH_WIDTH_POW),
    .HEIGHT_POW(`VIZ_HH_HEIGHT_POW),
    .CENTER_X  (`VIZ_HH_CX),
    .CENTER_Y  (`VIZ_HH_CY)
  ) u_hh (
    .clk      (clk),
    .rst      (rst),
    .pos      (pos),
    .noise    (noise),
    .intensity(shape[2])
  );

  // one-cycle shapes catch up with the star
  always_ff @(posedge clk) begin
    bd_d1 <= shape[0];
    bd_d2 <= bd_d1;
    sd_d1 <= shape[1];
    sd_d2 <= sd_d1;
  end

  assign mix_in[0] = bd_d2;
  assign mix_in[1] = sd_d2;
  assign mix_in[2] = shape[2];

  always_comb begin
    sum_full = '0;
    for (int i = 0; i < `VIZ_VOICES; i++) begin
      sum_full += env[i] * mix_in[i];
    end
    sum_sat = (sum_full > 18'h0FFFF) ? 16'hFFFF : sum_full[15:0];
  end

  always_ff @(posedge clk) begin
    intensity <= sum_sat[15:8];
  end

endmodule

//--- star_noise.sv
`timescale 1ns/1ns

module star_noise #(
  parameter int WIDTH_POW  = 6,
  parameter int HEIGHT_POW = 5,
  parameter int CENTER_X   = 260,
  parameter int CENTER_Y   = 150
) (
  input  logic                 clk,
  input  logic                 rst,
  input  viz_pkg::raster_pos_t pos,
  input  viz_pkg::level_t      noise,
  output viz_pkg::level_t      intensity
);

  localparam int MIN_POW   = (WIDTH_POW < HEIGHT_POW) ? WIDTH_POW : HEIGHT_POW;
  localparam int X_SHFT    = 9 - WIDTH_POW;
  localparam int Y_SHFT    = 9 - HEIGHT_POW;
  localparam int XXYY_SHFT = 4 * MIN_POW - 16;
  localparam logic [10:0] CX = 11'(CENTER_X);
  localparam logic [9:0]  CY = 10'(CENTER_Y);

  logic [10:0]     x_dist;
  logic [9:0]      y_dist;
  logic [10:0]     x_d1;
  logic [10:0]     x_d2;
  logic [9:0]      y_d1;
  logic [9:0]      y_d2;
  logic [15:0]     x_sq;
  logic [15:0]     y_sq;
  logic [31:0]     xxyy;
  logic [31:0]     sum;
  viz_pkg::level_t next_intensity;

  assign x_dist = (pos.h_count > CX) ? pos.h_count - CX : CX - pos.h_count;
  assign y_dist = (pos.v_count > CY) ? pos.v_count - CY : CY - pos.v_count;

  // stages one and two
  always_ff @(posedge clk) begin
    x_d1 <= x_dist;
    y_d1 <= y_dist;
    x_sq <= x_dist[7:0] * x_dist[7:0];
    y_sq <= y_dist[7:0] * y_dist[7:0];
    x_d2 <= x_d1;
    y_d2 <= y_d1;
    xxyy <= x_sq * y_sq;
  end

  // 256 + noise - x - y - xxyy, clamped to 0..255
  always_comb begin
    sum = noise + 32'd256 - (x_d2 << X_SHFT) - (y_d2 << Y_SHFT) - (xxyy >> XXYY_SHFT);
    if (sum[31] || x_d2 >= (1 << WIDTH_POW) || y_d2 >= (1 << HEIGHT_POW)) begin
      next_intensity = '0;
    end else begin
      next_intensity = sum[8] ? 8'hFF : sum[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      intensity <= '0;
    end else begin
      intensity <= next_intensity;
    end
  end

endmodule

//--- square_hollow_noise.sv
`timescale 1ns/1ns

module square_hollow_noise #(
  parameter int WIDTH    = 64,
  parameter int CENTER_X = 200,
  parameter int CENTER_Y = 60
) (
  input  logic                 clk,
  input  logic                 rst,
  input  viz_pkg::raster_pos_t pos,
  input  viz_pkg::level_t      noise,
  output viz_pkg::level_t      intensity
);

  localparam int HALF = WIDTH / 2;
  localparam int SHFT = 9 - $clog2(WIDTH);
  localparam int BIAS = 255 - ((HALF - 1) << SHFT);
  localparam logic [10:0] CX = 11'(CENTER_X);
  localparam logic [9:0]  CY = 10'(CENTER_Y);

  logic [10:0]     x_dist;
  logic [10:0]     y_dist;
  logic [10:0]     cheb;
  viz_pkg::level_t ramp;

  assign x_dist = (pos.h_count > CX) ? pos.h_count - CX : CX - pos.h_count;
  assign y_dist = {1'b0, (pos.v_count > CY) ? pos.v_count - CY : CY - pos.v_count};

  // chebyshev distance, brightest at the edge
  assign cheb = (x_dist < y_dist) ? y_dist : x_dist;
  assign ramp = viz_pkg::level_t'((cheb << SHFT) + BIAS);

  always_ff @(posedge clk) begin
    if (rst) begin
      intensity <= '0;
    end else if (x_dist < HALF && y_dist < HALF) begin
      intensity <= (ramp > noise) ? ramp : noise;
    end else begin
      intensity <= '0;
    end
  end

endmodule

//--- circle_hollow.sv
`timescale 1ns/1ns

module circle_hollow #(
  parameter int RADIUS   = 64,
  parameter int CENTER_X = 80,
  parameter int CENTER_Y = 100
) (
  input  logic                 clk,
  input  logic                 rst,
  input  viz_pkg::raster_pos_t pos,
  output viz_pkg::level_t      intensity
);

  localparam int RAD_SQ = RADIUS * RADIUS;
  localparam int SHFT   = $clog2(RAD_SQ) - 8;
  // lifts the rim to 255
  localparam int BIAS   = 255 - ((RAD_SQ - 1) >> SHFT);
  localparam logic [10:0] CX = 11'(CENTER_X);
  localparam logic [9:0]  CY = 10'(CENTER_Y);

  if (RADIUS < 16) begin : g_bad_radius
    $error("circle_hollow needs RADIUS of at least 16");
  end

  logic [10:0] x_dist;
  logic [9:0]  y_dist;
  logic [10:0] x_q;
  logic [9:0]  y_q;
  logic [16:0] rad_sq_q;

  assign x_dist = (pos.h_count > CX) ? pos.h_count - CX : CX - pos.h_count;
  assign y_dist = (pos.v_count > CY) ? pos.v_count - CY : CY - pos.v_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_q      <= '0;
      y_q      <= '0;
      rad_sq_q <= '0;
    end else begin
      x_q      <= x_dist;
      y_q      <= y_dist;
      rad_sq_q <= x_dist[7:0] * x_dist[7:0] + y_dist[7:0] * y_dist[7:0];
    end
  end

  always_comb begin
    if (x_q >= RADIUS || y_q >= RADIUS || rad_sq_q >= RAD_SQ) begin
      intensity = '0;
    end else begin
      intensity = viz_pkg::level_t'((rad_sq_q >> SHFT) + BIAS);
    end
  end

endmodule

//--- drum_envelope.sv
`timescale 1ns/1ns
`include "viz_consts.svh"

module drum_envelope (
  input  logic                 clk,
  input  logic                 rst,
  input  viz_pkg::voice_trig_t trig,
  input  logic                 frame_start,
  output viz_pkg::level_t      env [`VIZ_VOICES-1:0]
);

  localparam viz_pkg::level_t DECAY = `VIZ_DECAY_STEP;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `VIZ_VOICES; i++) begin
        env[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `VIZ_VOICES; i++) begin
        // strike wins over decay
        if (trig.strike[i]) begin
          env[i] <= trig.velocity;
        end else if (frame_start) begin
          env[i] <= (env[i] > DECAY) ? env[i] - DECAY : '0;
        end
      end
    end
  end

  for (genvar g = 0; g < `VIZ_VOICES; g++) begin : g_chk
    a_no_rise: assert property (@(posedge clk) disable iff (rst)
      !trig.strike[g] |=> env[g] <= $past(env[g]));
  end

endmodule

//--- video_timing.sv
`timescale 1ns/1ns
`include "viz_consts.svh"

module video_timing (
  input  logic                 clk,
  input  logic                 rst,
  output viz_pkg::raster_pos_t pos,
  output logic                 frame_start
);

  logic [10:0] h_next;
  logic [9:0]  v_next;
  logic        h_wrap;
  logic        v_wrap;

  always_comb begin
    h_wrap = (pos.h_count == `VIZ_H_TOTAL - 1);
    v_wrap = (pos.v_count == `VIZ_V_TOTAL - 1);
    h_next = h_wrap ? 11'd0 : pos.h_count + 11'd1;
    v_next = pos.v_count;
    if (h_wrap) begin
      v_next = v_wrap ? 10'd0 : pos.v_count + 10'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pos.h_count     <= 11'd0;
      pos.v_count     <= 10'd0;
      pos.active_draw <= 1'b1;
      frame_start     <= 1'b0;
    end else begin
      pos.h_count     <= h_next;
      pos.v_count     <= v_next;
      pos.active_draw <= (h_next < `VIZ_H_ACTIVE) && (v_next < `VIZ_V_ACTIVE);
      // high in the cycle the position reads 0,0
      frame_start     <= h_wrap && v_wrap;
    end
  end

  a_h_range: assert property (@(posedge clk) disable iff (rst)
    pos.h_count < `VIZ_H_TOTAL);

endmodule

//--- viz_pkg.sv
`include "viz_consts.svh"

package viz_pkg;

  // grey level, also used for envelopes and shape outputs
  typedef logic [7:0] level_t;

  typedef struct packed {
    logic [10:0] h_count;
    logic [9:0]  v_count;
    logic        active_draw;
  } raster_pos_t;

  // one velocity shared by every voice struck in the same cycle
  typedef struct packed {
    logic [`VIZ_VOICES-1:0] strike;
    level_t                 velocity;
  } voice_trig_t;

endpackage

//--- viz_consts.svh
`ifndef VIZ_CONSTS_SVH
`define VIZ_CONSTS_SVH

// reduced raster so a run covers several frames
`define VIZ_H_TOTAL 400
`define VIZ_V_TOTAL 220
`define VIZ_H_ACTIVE 320
`define VIZ_V_ACTIVE 200

`define VIZ_VOICES 3

// bass drum ring
`define VIZ_BD_RADIUS 64
`define VIZ_BD_CX 80
`define VIZ_BD_CY 100

// snare square
`define VIZ_SD_WIDTH 64
`define VIZ_SD_CX 200
`define VIZ_SD_CY 60

// hi-hat star, extents as powers of two
`define VIZ_HH_WIDTH_POW 6
`define VIZ_HH_HEIGHT_POW 5
`define VIZ_HH_CX 260
`define VIZ_HH_CY 150

`define VIZ_DECAY_STEP 32
`define VIZ_LFSR_SEED 32'hFFFF_FFFF
`define VIZ_LFSR_TAPS 32'h04C1_1DB7

// position to pixel latency
`define VIZ_PIPE_DEPTH 4

`endif
